/* hdl/vita_tx_pkg.sv */
`default_nettype none

package vita_tx_pkg;

   // one input word, read as a vita header or as an i/q sample
   typedef union packed {
      struct packed {
         logic [3:0]  pkt_type;  // 0001 -> stream id follows
         logic        has_classid;
         logic        has_trailer;
         logic        sob;
         logic        eob;
         logic [1:0]  tsi;       // nonzero -> seconds word
         logic [1:0]  tsf;       // nonzero -> two tics words
         logic [3:0]  seqnum;
         logic [15:0] pkt_len;   // words incl. header
      } hdr;
      struct packed {
         logic [15:0] i_val;
         logic [15:0] q_val;
      } smp;
   } vita_word_u;

   localparam int MAX_CHAN = 4;
   localparam int LINE_W   = 32 * MAX_CHAN;

   localparam logic [7:0] SET_ADDR_CHAN0 = 8'h20;
   localparam logic [7:0] SET_ADDR_CHAN1 = 8'h21;

   localparam int QUEUE_DEPTH = 4;
   localparam int PTR_W       = $clog2(QUEUE_DEPTH);
   // samples, send time, seqnum and five flags
   localparam int ENTRY_W     = LINE_W + 64 + 4 + 5;

   localparam logic [3:0] ST_HEADER   = 4'd0;
   localparam logic [3:0] ST_STREAMID = 4'd1;
   localparam logic [3:0] ST_CLASSID  = 4'd2;
   localparam logic [3:0] ST_CLASSID2 = 4'd3;
   localparam logic [3:0] ST_SECS     = 4'd4;
   localparam logic [3:0] ST_TICS     = 4'd5;
   localparam logic [3:0] ST_TICS2    = 4'd6;
   localparam logic [3:0] ST_PAYLOAD  = 4'd7;
   localparam logic [3:0] ST_STORE    = 4'd8;
   localparam logic [3:0] ST_TRAILER  = 4'd9;

endpackage

`default_nettype wire

/* hdl/tx_setting_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_setting_regs import vita_tx_pkg::*;
(
   input  wire         clk,
   input  wire         arst_n_i,
   input  wire         set_stb_i,
   input  wire  [7:0]  set_addr_i,
   input  wire  [31:0] set_data_i,
   output logic [1:0]  numchan0_o,
   output logic [1:0]  numchan1_o,
   output logic        enable0_o,
   output logic        enable1_o
);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         numchan0_o <= 2'd0;  // one channel
         numchan1_o <= 2'd0;
         enable0_o  <= 1'b0;
         enable1_o  <= 1'b0;
      end
      else if (set_stb_i)
      begin
         if (set_addr_i == SET_ADDR_CHAN0)
         begin
            numchan0_o <= set_data_i[1:0];
            enable0_o  <= set_data_i[31];
         end
         if (set_addr_i == SET_ADDR_CHAN1)
         begin
            numchan1_o <= set_data_i[1:0];
            enable1_o  <= set_data_i[31];
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/vita_tx_deframer.sv */
`timescale 1ns/10ps
`default_nettype none

module vita_tx_deframer import vita_tx_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n_i,
   input  wire               enable_i,
   input  wire  [1:0]        numchan_i,
   input  wire  [31:0]       pkt_data_i,
   input  wire               pkt_eof_i,
   input  wire               pkt_valid_i,
   output logic              pkt_ready_o,
   output logic [LINE_W-1:0] line_samples_o,
   output logic [63:0]       line_send_time_o,
   output logic [3:0]        line_seqnum_o,
   output logic              line_send_at_o,
   output logic              line_sob_o,
   output logic              line_eob_o,
   output logic              line_eop_o,
   output logic              line_seq_err_o,
   output logic              line_valid_o,
   input  wire               line_ready_i
);

   vita_word_u        word;
   logic [3:0]        state;
   logic [1:0]        phase;
   logic [1:0]        numchan_r;
   logic [15:0]       rem_cnt;  // packet words still to come
   logic              cid_r, secs_r, tics_r, trailer_r, sob_r, eob_r;
   logic              eop_r, eof_r, seq_err_r;
   logic [3:0]        seqnum_r;
   logic [63:0]       send_time;
   logic [LINE_W-1:0] samples;
   logic              xfer, last_pld, line_end;

   // first optional header word still pending, else payload
   function automatic logic [3:0] opt_next(input logic cid, input logic secs, input logic tics);
      if (cid)
         return ST_CLASSID;
      if (secs)
         return ST_SECS;
      if (tics)
         return ST_TICS;
      return ST_PAYLOAD;
   endfunction

   assign word     = pkt_data_i;
   assign xfer     = pkt_valid_i & pkt_ready_o;
   assign last_pld = rem_cnt == (trailer_r ? 16'd2 : 16'd1);
   assign line_end = (phase == numchan_r) | last_pld | pkt_eof_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state     <= ST_HEADER;
         phase     <= 2'd0;
         numchan_r <= 2'd0;
         rem_cnt   <= 16'd0;
         {cid_r, secs_r, tics_r, trailer_r, sob_r, eob_r} <= '0;
         {eop_r, eof_r, seq_err_r} <= '0;
         seqnum_r  <= 4'd0;
      end
      else if (!enable_i)
      begin
         state    <= ST_HEADER;  // disable acts as a clear
         phase    <= 2'd0;
         seqnum_r <= 4'd0;
      end
      else if (state == ST_STORE)
      begin
         if (line_ready_i)
         begin
            if (!eop_r)
               state <= ST_PAYLOAD;
            else if (trailer_r && !eof_r)
               state <= ST_TRAILER;
            else
               state <= ST_HEADER;
         end
      end
      else if (xfer)
      begin
         if (state != ST_HEADER)
            rem_cnt <= rem_cnt - 16'd1;
         case (state)
            ST_HEADER:
            begin
               cid_r     <= word.hdr.has_classid;
               secs_r    <= |word.hdr.tsi;
               tics_r    <= |word.hdr.tsf;
               trailer_r <= word.hdr.has_trailer;
               sob_r     <= word.hdr.sob;
               eob_r     <= word.hdr.eob;
               rem_cnt   <= word.hdr.pkt_len - 16'd1;
               numchan_r <= numchan_i;
               phase     <= 2'd0;
               seqnum_r  <= word.hdr.seqnum;
               seq_err_r <= word.hdr.seqnum != seqnum_r + 4'd1;
               if (word.hdr.pkt_type == 4'b0001)
                  state <= ST_STREAMID;
               else
                  state <= opt_next(word.hdr.has_classid, |word.hdr.tsi, |word.hdr.tsf);
            end
            ST_STREAMID: state <= opt_next(cid_r, secs_r, tics_r);
            ST_CLASSID:  state <= ST_CLASSID2;
            ST_CLASSID2: state <= opt_next(1'b0, secs_r, tics_r);
            ST_SECS:     state <= opt_next(1'b0, 1'b0, tics_r);
            ST_TICS:     state <= ST_TICS2;
            ST_TICS2:    state <= ST_PAYLOAD;
            ST_PAYLOAD:
            begin
               if (line_end)
               begin
                  phase <= 2'd0;
                  eop_r <= last_pld | pkt_eof_i;
                  eof_r <= pkt_eof_i;
                  state <= ST_STORE;
               end
               else
                  phase <= phase + 2'd1;
            end
            default:     state <= ST_HEADER;  // trailer word
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
      begin
         case (state)
            ST_HEADER: send_time <= 64'd0;
            ST_SECS:   send_time[63:32] <= word;
            ST_TICS2:  send_time[31:0] <= word;
            ST_PAYLOAD:
            begin
               if (phase == 2'd0)
                  samples <= {{(LINE_W-32){1'b0}}, word.smp};  // unused lanes stay zero
               else
                  samples[32*phase +: 32] <= word.smp;
            end
            default: ;
         endcase
      end
   end

   assign pkt_ready_o      = enable_i & (state != ST_STORE);
   assign line_valid_o     = enable_i & (state == ST_STORE);
   assign line_samples_o   = samples;
   assign line_send_time_o = send_time;
   assign line_seqnum_o    = seqnum_r;
   assign line_send_at_o   = secs_r;
   assign line_sob_o       = sob_r;
   assign line_eob_o       = eob_r;
   assign line_eop_o       = eop_r;
   assign line_seq_err_o   = seq_err_r;

endmodule

`default_nettype wire

/* hdl/sample_line_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_line_queue import vita_tx_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n_i,
   input  wire  [LINE_W-1:0] samples_i,
   input  wire  [63:0]       send_time_i,
   input  wire  [3:0]        seqnum_i,
   input  wire               send_at_i,
   input  wire               sob_i,
   input  wire               eob_i,
   input  wire               eop_i,
   input  wire               seq_err_i,
   input  wire               in_valid_i,
   output logic              in_ready_o,
   output logic [LINE_W-1:0] samples_o,
   output logic [63:0]       send_time_o,
   output logic [3:0]        seqnum_o,
   output logic              send_at_o,
   output logic              sob_o,
   output logic              eob_o,
   output logic              eop_o,
   output logic              seq_err_o,
   output logic              out_valid_o,
   input  wire               out_ready_i
);

   logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
   logic [PTR_W-1:0]   wr_ptr, rd_ptr;
   logic [PTR_W:0]     count;
   logic               push, pop;

   assign in_ready_o  = count != (PTR_W+1)'(QUEUE_DEPTH);
   assign out_valid_o = count != '0;
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= {samples_i, send_time_i, seqnum_i, send_at_i, sob_i, eob_i, eop_i,
                         seq_err_i};
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // fall-through read of the head entry
   assign {samples_o, send_time_o, seqnum_o, send_at_o, sob_o, eob_o, eop_o, seq_err_o} =
      mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/sample_bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_bus_arbiter import vita_tx_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n_i,
   input  wire  [LINE_W-1:0] q0_samples_i,
   input  wire  [63:0]       q0_send_time_i,
   input  wire  [3:0]        q0_seqnum_i,
   input  wire               q0_send_at_i,
   input  wire               q0_sob_i,
   input  wire               q0_eob_i,
   input  wire               q0_eop_i,
   input  wire               q0_seq_err_i,
   input  wire               q0_valid_i,
   output logic              q0_ready_o,
   input  wire  [LINE_W-1:0] q1_samples_i,
   input  wire  [63:0]       q1_send_time_i,
   input  wire  [3:0]        q1_seqnum_i,
   input  wire               q1_send_at_i,
   input  wire               q1_sob_i,
   input  wire               q1_eob_i,
   input  wire               q1_eop_i,
   input  wire               q1_seq_err_i,
   input  wire               q1_valid_i,
   output logic              q1_ready_o,
   output logic [LINE_W-1:0] smp_data_o,
   output logic [63:0]       smp_send_time_o,
   output logic [3:0]        smp_seqnum_o,
   output logic              smp_send_at_o,
   output logic              smp_sob_o,
   output logic              smp_eob_o,
   output logic              smp_eop_o,
   output logic              smp_seq_err_o,
   output logic              smp_src_o,
   output logic              smp_valid_o,
   input  wire               smp_ready_i
);

   logic last_grant;
   logic locked;
   logic sel;

   always_comb
   begin
      if (locked)
         sel = last_grant;
      else if (q0_valid_i && q1_valid_i)
         sel = ~last_grant;  // alternate when both wait
      else
         sel = q1_valid_i;
   end

   assign smp_src_o       = sel;
   assign smp_valid_o     = sel ? q1_valid_i : q0_valid_i;
   assign smp_data_o      = sel ? q1_samples_i : q0_samples_i;
   assign smp_send_time_o = sel ? q1_send_time_i : q0_send_time_i;
   assign smp_seqnum_o    = sel ? q1_seqnum_i : q0_seqnum_i;
   assign smp_send_at_o   = sel ? q1_send_at_i : q0_send_at_i;
   assign smp_sob_o       = sel ? q1_sob_i : q0_sob_i;
   assign smp_eob_o       = sel ? q1_eob_i : q0_eob_i;
   assign smp_eop_o       = sel ? q1_eop_i : q0_eop_i;
   assign smp_seq_err_o   = sel ? q1_seq_err_i : q0_seq_err_i;
   assign q0_ready_o      = ~sel & smp_ready_i;
   assign q1_ready_o      = sel & smp_ready_i;

   // lock as soon as a line is offered, so the bus stays stable until taken
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         last_grant <= 1'b1;  // stream 0 wins the first tie
         locked     <= 1'b0;
      end
      else if (smp_valid_o)
      begin
         last_grant <= sel;
         locked     <= ~(smp_ready_i & smp_eop_o);
      end
   end

endmodule

`default_nettype wire

/* hdl/vita_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vita_tx_top import vita_tx_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n_i,
   input  wire               set_stb_i,
   input  wire  [7:0]        set_addr_i,
   input  wire  [31:0]       set_data_i,
   input  wire  [31:0]       pkt_data_0_i,
   input  wire               pkt_eof_0_i,
   input  wire               pkt_valid_0_i,
   output logic              pkt_ready_0_o,
   input  wire  [31:0]       pkt_data_1_i,
   input  wire               pkt_eof_1_i,
   input  wire               pkt_valid_1_i,
   output logic              pkt_ready_1_o,
   output logic [LINE_W-1:0] smp_data_o,
   output logic [63:0]       smp_send_time_o,
   output logic [3:0]        smp_seqnum_o,
   output logic              smp_send_at_o,
   output logic              smp_sob_o,
   output logic              smp_eob_o,
   output logic              smp_eop_o,
   output logic              smp_seq_err_o,
   output logic              smp_src_o,
   output logic              smp_valid_o,
   input  wire               smp_ready_i
);

   logic [1:0]        numchan0, numchan1;
   logic              enable0, enable1;
   // deframer to queue
   logic [LINE_W-1:0] l0_samples, l1_samples;
   logic [63:0]       l0_time, l1_time;
   logic [3:0]        l0_seq, l1_seq;
   logic              l0_send_at, l0_sob, l0_eob, l0_eop, l0_seq_err, l0_valid, l0_ready;
   logic              l1_send_at, l1_sob, l1_eob, l1_eop, l1_seq_err, l1_valid, l1_ready;
   // queue to arbiter
   logic [LINE_W-1:0] q0_samples, q1_samples;
   logic [63:0]       q0_time, q1_time;
   logic [3:0]        q0_seq, q1_seq;
   logic              q0_send_at, q0_sob, q0_eob, q0_eop, q0_seq_err, q0_valid, q0_ready;
   logic              q1_send_at, q1_sob, q1_eob, q1_eop, q1_seq_err, q1_valid, q1_ready;

   tx_setting_regs setting_regs (
      .clk(clk), .arst_n_i(arst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .numchan0_o(numchan0), .numchan1_o(numchan1),
      .enable0_o(enable0), .enable1_o(enable1)
   );

   vita_tx_deframer deframer0 (
      .clk(clk), .arst_n_i(arst_n_i), .enable_i(enable0), .numchan_i(numchan0),
      .pkt_data_i(pkt_data_0_i), .pkt_eof_i(pkt_eof_0_i),
      .pkt_valid_i(pkt_valid_0_i), .pkt_ready_o(pkt_ready_0_o),
      .line_samples_o(l0_samples), .line_send_time_o(l0_time), .line_seqnum_o(l0_seq),
      .line_send_at_o(l0_send_at), .line_sob_o(l0_sob), .line_eob_o(l0_eob),
      .line_eop_o(l0_eop), .line_seq_err_o(l0_seq_err),
      .line_valid_o(l0_valid), .line_ready_i(l0_ready)
   );

   vita_tx_deframer deframer1 (
      .clk(clk), .arst_n_i(arst_n_i), .enable_i(enable1), .numchan_i(numchan1),
      .pkt_data_i(pkt_data_1_i), .pkt_eof_i(pkt_eof_1_i),
      .pkt_valid_i(pkt_valid_1_i), .pkt_ready_o(pkt_ready_1_o),
      .line_samples_o(l1_samples), .line_send_time_o(l1_time), .line_seqnum_o(l1_seq),
      .line_send_at_o(l1_send_at), .line_sob_o(l1_sob), .line_eob_o(l1_eob),
      .line_eop_o(l1_eop), .line_seq_err_o(l1_seq_err),
      .line_valid_o(l1_valid), .line_ready_i(l1_ready)
   );

   sample_line_queue queue0 (
      .clk(clk), .arst_n_i(arst_n_i),
      .samples_i(l0_samples), .send_time_i(l0_time), .seqnum_i(l0_seq),
      .send_at_i(l0_send_at), .sob_i(l0_sob), .eob_i(l0_eob), .eop_i(l0_eop),
      .seq_err_i(l0_seq_err), .in_valid_i(l0_valid), .in_ready_o(l0_ready),
      .samples_o(q0_samples), .send_time_o(q0_time), .seqnum_o(q0_seq),
      .send_at_o(q0_send_at), .sob_o(q0_sob), .eob_o(q0_eob), .eop_o(q0_eop),
      .seq_err_o(q0_seq_err), .out_valid_o(q0_valid), .out_ready_i(q0_ready)
   );

   sample_line_queue queue1 (
      .clk(clk), .arst_n_i(arst_n_i),
      .samples_i(l1_samples), .send_time_i(l1_time), .seqnum_i(l1_seq),
      .send_at_i(l1_send_at), .sob_i(l1_sob), .eob_i(l1_eob), .eop_i(l1_eop),
      .seq_err_i(l1_seq_err), .in_valid_i(l1_valid), .in_ready_o(l1_ready),
      .samples_o(q1_samples), .send_time_o(q1_time), .seqnum_o(q1_seq),
      .send_at_o(q1_send_at), .sob_o(q1_sob), .eob_o(q1_eob), .eop_o(q1_eop),
      .seq_err_o(q1_seq_err), .out_valid_o(q1_valid), .out_ready_i(q1_ready)
   );

   sample_bus_arbiter arbiter (
      .clk(clk), .arst_n_i(arst_n_i),
      .q0_samples_i(q0_samples), .q0_send_time_i(q0_time), .q0_seqnum_i(q0_seq),
      .q0_send_at_i(q0_send_at), .q0_sob_i(q0_sob), .q0_eob_i(q0_eob),
      .q0_eop_i(q0_eop), .q0_seq_err_i(q0_seq_err),
      .q0_valid_i(q0_valid), .q0_ready_o(q0_ready),
      .q1_samples_i(q1_samples), .q1_send_time_i(q1_time), .q1_seqnum_i(q1_seq),
      .q1_send_at_i(q1_send_at), .q1_sob_i(q1_sob), .q1_eob_i(q1_eob),
      .q1_eop_i(q1_eop), .q1_seq_err_i(q1_seq_err),
      .q1_valid_i(q1_valid), .q1_ready_o(q1_ready),
      .smp_data_o(smp_data_o), .smp_send_time_o(smp_send_time_o),
      .smp_seqnum_o(smp_seqnum_o), .smp_send_at_o(smp_send_at_o),
      .smp_sob_o(smp_sob_o), .smp_eob_o(smp_eob_o), .smp_eop_o(smp_eop_o),
      .smp_seq_err_o(smp_seq_err_o), .smp_src_o(smp_src_o),
      .smp_valid_o(smp_valid_o), .smp_ready_i(smp_ready_i)
   );

endmodule

`default_nettype wire

/* verification/vita_tx_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module vita_tx_checker import vita_tx_pkg::*;
(
   input wire              clk,
   input wire              arst_n_i,
   input wire              valid_i,
   input wire              ready_i,
   input wire              src_i,
   input wire              eop_i,
   input wire [LINE_W-1:0] data_i
);

   int fail_count = 0;

   // an offered line stays put until it is taken
   stable_while_stalled: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(src_i))
   else
   begin
      fail_count++;
      $error("sample bus changed while stalled");
   end

   // grant stays on the stream even while its queue runs dry
   grant_held_to_eop: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i && ready_i && !eop_i |=> src_i == $past(src_i))
   else
   begin
      fail_count++;
      $error("grant moved to the other stream inside a packet");
   end

   no_valid_in_reset: assert property (@(posedge clk) !arst_n_i |-> !valid_i)
   else
   begin
      fail_count++;
      $error("smp_valid_o high during reset");
   end

endmodule

bind sample_bus_arbiter vita_tx_checker checker0 (
   .clk(clk), .arst_n_i(arst_n_i), .valid_i(smp_valid_o), .ready_i(smp_ready_i),
   .src_i(smp_src_o), .eop_i(smp_eop_o), .data_i(smp_data_o)
);

`default_nettype wire

/* verification/vita_tx_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module vita_tx_monitor import vita_tx_pkg::*;
(
   input wire              clk,
   input wire              arst_n_i,
   input wire [LINE_W-1:0] smp_data_i,
   input wire [63:0]       smp_send_time_i,
   input wire [3:0]        smp_seqnum_i,
   input wire              smp_send_at_i,
   input wire              smp_sob_i,
   input wire              smp_eob_i,
   input wire              smp_eop_i,
   input wire              smp_seq_err_i,
   input wire              smp_src_i,
   input wire              smp_valid_i,
   input wire              smp_ready_i,
   input wire              q0_valid_i,
   input wire              q1_valid_i
);

   // samples, send time, seqnum, send_at, sob, eob, eop, seq_err
   localparam int EXP_W = LINE_W + 64 + 9;

   logic [EXP_W-1:0]  exp0 [$];
   logic [EXP_W-1:0]  exp1 [$];
   int                idx [2];  // word position inside the packet
   int                plen [2];
   int                n_hdr [2];
   int                n_pld [2];
   int                secs_pos [2];
   int                lane [2];
   logic              secs_f [2];
   logic              tics_f [2];
   logic [1:0]        nchan [2];
   logic [3:0]        prev_seq [2];
   logic [6:0]        info [2];  // seqnum, send_at, sob, eob
   logic              seq_err [2];
   logic [63:0]       stime [2];
   logic [LINE_W-1:0] acc [2];
   logic              in_pkt;
   logic              held;
   logic              granted_once;
   logic              last_src;
   logic              pkt_src;
   int                errors;
   int                lines;
   int                tests;
   int                last_errors;
   int                last_lines;

   initial
   begin
      for (int s = 0; s < 2; s++)
      begin
         idx[s]      = 0;
         lane[s]     = 0;
         prev_seq[s] = 4'd0;
         acc[s]      = '0;
      end
      {in_pkt, held, granted_once, last_src, pkt_src} = '0;
      {errors, lines, tests, last_errors, last_lines} = '0;
   end

   task automatic note_failure(input string msg);
      $display("%0t: %s", $time, msg);
      errors++;
   endtask

   function automatic int pending_lines();
      return exp0.size() + exp1.size();
   endfunction

   // rebuild expected lines from every word accepted on stream s
   task automatic push_word(input int s, input logic [31:0] w, input logic eof,
                            input logic [1:0] nc);
      vita_word_u vw;
      int         p;
      logic       last;
      vw = w;
      p  = idx[s];
      if (p == 0)
      begin
         secs_f[s]   = vw.hdr.tsi != 2'd0;
         tics_f[s]   = vw.hdr.tsf != 2'd0;
         secs_pos[s] = 1 + int'(vw.hdr.pkt_type == 4'b0001) + 2 * int'(vw.hdr.has_classid);
         n_hdr[s]    = secs_pos[s] + int'(secs_f[s]) + 2 * int'(tics_f[s]);
         plen[s]     = int'(vw.hdr.pkt_len);
         n_pld[s]    = plen[s] - n_hdr[s] - int'(vw.hdr.has_trailer);
         seq_err[s]  = vw.hdr.seqnum != prev_seq[s] + 4'd1;
         prev_seq[s] = vw.hdr.seqnum;
         info[s]     = {vw.hdr.seqnum, secs_f[s], vw.hdr.sob, vw.hdr.eob};
         stime[s]    = 64'd0;
         nchan[s]    = nc;
         lane[s]     = 0;
         acc[s]      = '0;
      end
      else if (p >= n_hdr[s])
      begin
         if (p < n_hdr[s] + n_pld[s])  // else the trailer word
         begin
            acc[s][32*lane[s] +: 32] = w;
            lane[s] = lane[s] + 1;
            last = p == n_hdr[s] + n_pld[s] - 1;
            if (lane[s] == int'(nchan[s]) + 1 || last || eof)
            begin
               if (s == 0)
                  exp0.push_back({acc[s], stime[s], info[s], last | eof, seq_err[s]});
               else
                  exp1.push_back({acc[s], stime[s], info[s], last | eof, seq_err[s]});
               lane[s] = 0;
               acc[s]  = '0;
            end
         end
      end
      else if (secs_f[s] && p == secs_pos[s])
         stime[s][63:32] = w;
      else if (tics_f[s] && p == secs_pos[s] + int'(secs_f[s]) + 1)
         stime[s][31:0] = w;  // second tics word
      idx[s] = (eof || p + 1 == plen[s]) ? 0 : p + 1;
   endtask

   task automatic compare(input string name, input logic [LINE_W-1:0] got,
                          input logic [LINE_W-1:0] expv);
      if (got !== expv)
      begin
         $display("ERROR %0t %s: got %0h expected %0h", $time, name, got, expv);
         errors++;
      end
   endtask

   task automatic check_line();
      logic [EXP_W-1:0] e;
      lines++;
      if (in_pkt && smp_src_i != pkt_src)
         note_failure($sformatf("stream %0d line inside a packet of stream %0d",
                                smp_src_i, pkt_src));
      in_pkt  = !smp_eop_i;
      pkt_src = smp_src_i;
      if ((smp_src_i ? exp1.size() : exp0.size()) == 0)
      begin
         note_failure($sformatf("unexpected line from stream %0d", smp_src_i));
         return;
      end
      if (smp_src_i)
         e = exp1.pop_front();
      else
         e = exp0.pop_front();
      compare("smp_data_o", smp_data_i, e[EXP_W-1 -: LINE_W]);
      compare("smp_send_time_o", smp_send_time_i, e[72:9]);
      compare("smp_seqnum_o", smp_seqnum_i, e[8:5]);
      compare("smp_send_at_o", smp_send_at_i, e[4]);
      compare("smp_sob_o", smp_sob_i, e[3]);
      compare("smp_eob_o", smp_eob_i, e[2]);
      compare("smp_eop_o", smp_eop_i, e[1]);
      compare("smp_seq_err_o", smp_seq_err_i, e[0]);
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("test %0d %s: %0d lines, %0d errors", tests, name,
               lines - last_lines, errors - last_errors);
      last_lines  = lines;
      last_errors = errors;
   endtask

   always @(posedge clk)
   begin
      // new grant decision when the bus is idle
      if (arst_n_i && smp_valid_i && !held)
      begin
         if (granted_once && q0_valid_i && q1_valid_i && smp_src_i == last_src)
            note_failure($sformatf("stream %0d granted twice while both streams waited",
                                   smp_src_i));
         held         = 1'b1;
         granted_once = 1'b1;
         last_src     = smp_src_i;
      end
      if (arst_n_i && smp_valid_i && smp_ready_i)
      begin
         check_line();
         if (smp_eop_i)
            held = 1'b0;
      end
   end

endmodule

`default_nettype wire

/* verification/vita_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vita_tx_tb
   import vita_tx_pkg::*;
();

   localparam int MAX_PKT_WORDS = 17;  // all header options, 9 payload words, trailer

   logic              clk;
   logic              arst_n_i;
   logic              set_stb_i;
   logic [7:0]        set_addr_i;
   logic [31:0]       set_data_i;
   logic [31:0]       pkt_data_0_i;
   logic              pkt_eof_0_i;
   logic              pkt_valid_0_i;
   logic              pkt_ready_0_o;
   logic [31:0]       pkt_data_1_i;
   logic              pkt_eof_1_i;
   logic              pkt_valid_1_i;
   logic              pkt_ready_1_o;
   logic [LINE_W-1:0] smp_data_o;
   logic [63:0]       smp_send_time_o;
   logic [3:0]        smp_seqnum_o;
   logic              smp_send_at_o;
   logic              smp_sob_o;
   logic              smp_eob_o;
   logic              smp_eop_o;
   logic              smp_seq_err_o;
   logic              smp_src_o;
   logic              smp_valid_o;
   logic              smp_ready_i;

   integer            seed = 32'hf5c095cb;
   int                planned_words = 0;
   int                cycles = 0;
   int                total_errors;
   logic              watch_disabled = 1'b0;
   logic [1:0]        cur_nc [2];
   logic [3:0]        gen_seq [2];

   vita_tx_top dut0 (.*);

   vita_tx_monitor mon0 (
      .clk(clk), .arst_n_i(arst_n_i),
      .smp_data_i(smp_data_o), .smp_send_time_i(smp_send_time_o),
      .smp_seqnum_i(smp_seqnum_o), .smp_send_at_i(smp_send_at_o),
      .smp_sob_i(smp_sob_o), .smp_eob_i(smp_eob_o), .smp_eop_i(smp_eop_o),
      .smp_seq_err_i(smp_seq_err_o), .smp_src_i(smp_src_o),
      .smp_valid_i(smp_valid_o), .smp_ready_i(smp_ready_i),
      .q0_valid_i(dut0.q0_valid), .q1_valid_i(dut0.q1_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // random back-pressure, ready about three cycles in four
   always @(posedge clk)
      smp_ready_i <= arst_n_i && (($random(seed) & 3) != 0);

   always @(posedge clk)
   begin
      if (watch_disabled && pkt_ready_0_o)
         mon0.note_failure("pkt_ready_0_o high while stream 0 is disabled");
   end

   initial
   begin : watchdog
      while (cycles <= 40 * (planned_words + 64))
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles with %0d lines still missing",
               cycles, mon0.pending_lines());
      $display("*** TEST FAILED ***");
      $finish;
   end

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge clk);
      set_stb_i  <= 1'b0;
   endtask

   task automatic drive_word(input int s, input logic valid, input logic [31:0] w,
                             input logic eof);
      if (s == 0)
      begin
         pkt_valid_0_i <= valid;
         pkt_data_0_i  <= w;
         pkt_eof_0_i   <= eof;
      end
      else
      begin
         pkt_valid_1_i <= valid;
         pkt_data_1_i  <= w;
         pkt_eof_1_i   <= eof;
      end
   endtask

   task automatic send_word(input int s, input logic [31:0] w, input logic eof);
      logic done;
      done = 1'b0;
      if (($random(seed) & 3) == 0)
      begin
         drive_word(s, 1'b0, w, 1'b0);  // idle gap
         @(posedge clk);
      end
      drive_word(s, 1'b1, w, eof);
      while (!done)
      begin
         @(posedge clk);
         done = (s == 0) ? pkt_ready_0_o : pkt_ready_1_o;
      end
      mon0.push_word(s, w, eof, cur_nc[s]);
   endtask

   task automatic run_stream(input int s, input int npkts);
      logic sid, cid, trl, sob, eob;
      logic [1:0] tsi, tsf;
      int   npld, cut, nhdr, len, nw;
      for (int k = 0; k < npkts; k++)
      begin
         sid  = 1'($random(seed));
         cid  = 1'($random(seed));
         trl  = 1'($random(seed));
         sob  = 1'($random(seed));
         eob  = 1'($random(seed));
         tsi  = 2'($random(seed));
         tsf  = 2'($random(seed));
         // one packet in eight skips a sequence number
         gen_seq[s] = gen_seq[s] + ((($random(seed) & 7) == 0) ? 4'd2 : 4'd1);
         npld = 1 + int'($unsigned($random(seed)) % 9);
         cut  = (($random(seed) & 7) == 0) ? int'($unsigned($random(seed)) % npld) : npld;
         nhdr = 1 + int'(sid) + 2 * int'(cid) + int'(tsi != 0) + 2 * int'(tsf != 0);
         len  = nhdr + npld + int'(trl);
         nw   = (cut < npld) ? nhdr + cut + 1 : len;  // early eof ends the packet
         send_word(s, {sid ? 4'b0001 : 4'b0000, cid, trl, sob, eob, tsi, tsf,
                       gen_seq[s], 16'(len)}, 1'b0);
         for (int i = 1; i < nw; i++)
            send_word(s, $random(seed), i == nw - 1);
      end
      drive_word(s, 1'b0, 32'd0, 1'b0);
   endtask

   task automatic wait_drain();
      while (mon0.pending_lines() != 0)
         @(posedge clk);
      repeat (16)
         @(posedge clk);
   endtask

   task automatic run_test(input string name, input logic [1:0] nc, input int npkts);
      cur_nc[0] = nc;
      cur_nc[1] = nc;
      write_setting(SET_ADDR_CHAN0, {1'b1, 29'd0, nc});
      write_setting(SET_ADDR_CHAN1, {1'b1, 29'd0, nc});
      planned_words += 2 * npkts * MAX_PKT_WORDS;
      fork
         run_stream(0, npkts);
         run_stream(1, npkts);
      join
      wait_drain();
      mon0.report_test(name);
   endtask

   initial
   begin : main
      arst_n_i    = 1'b0;
      set_stb_i   = 1'b0;
      set_addr_i  = 8'd0;
      set_data_i  = 32'd0;
      smp_ready_i = 1'b0;
      drive_word(0, 1'b0, 32'd0, 1'b0);
      drive_word(1, 1'b0, 32'd0, 1'b0);
      gen_seq[0]  = 4'd0;
      gen_seq[1]  = 4'd0;
      repeat (8)
         @(posedge clk);
      arst_n_i <= 1'b1;
      repeat (2)
         @(posedge clk);
      if (smp_valid_o || pkt_ready_0_o || pkt_ready_1_o)
         mon0.note_failure("output valid or packet ready high after reset");
      mon0.report_test("reset state");

      // stream 1 only, stream 0 offers a word that must never be taken
      cur_nc[1] = 2'd1;
      write_setting(SET_ADDR_CHAN1, {1'b1, 29'd0, 2'd1});
      planned_words += 6 * MAX_PKT_WORDS;
      drive_word(0, 1'b1, 32'h0001_0004, 1'b0);
      watch_disabled = 1'b1;
      run_stream(1, 6);
      wait_drain();
      watch_disabled = 1'b0;
      drive_word(0, 1'b0, 32'd0, 1'b0);
      mon0.report_test("stream 0 disabled");

      for (int nc = 0; nc < 4; nc++)
         run_test($sformatf("both streams, %0d channels", nc + 1), 2'(nc), 12);

      total_errors = mon0.errors + dut0.arbiter.checker0.fail_count;
      $display("tests %0d, lines %0d, errors %0d", mon0.tests, mon0.lines, total_errors);
      if (total_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
hdl/vita_tx_pkg.sv
hdl/tx_setting_regs.sv
hdl/vita_tx_deframer.sv
hdl/sample_line_queue.sv
hdl/sample_bus_arbiter.sv
hdl/vita_tx_top.sv
verification/vita_tx_checker.sv
verification/vita_tx_monitor.sv
verification/vita_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module vita_tx_tb \
   -o vita_tx_sim
./obj_dir/vita_tx_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -qF '*** TEST PASSED ***' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
